// ==== cw_backoff_tracker.sv ====
// backoff tracker: per-queue contention window exponent and random slot draw per attempt
`timescale 1ns/100ps
`default_nettype none

module cw_backoff_tracker
    import tx_status_cfg_pkg::*;
    import tx_status_types_pkg::*;
#(
    parameter int unsigned cw_min = cw_min_default,
    parameter int unsigned cw_max = cw_max_default
) (
    input  wire             clk,
    input  wire             rstn,

    // completion of one transmit attempt, fields valid with the strobe
    input  wire             tx_try_complete,
    input  wire tx_result_t tx_result,
    input  wire prio_t      linux_prio,
    input  wire queue_idx_t tx_queue_idx,
    input  wire pkt_sn_t    tx_pkt_sn,

    // one-cycle record strobe to the logging stage
    output logic            attempt_valid,
    output tx_attempt_t     attempt
);

    // exponent bounds in field width
    localparam cw_exp_t cw_min_exp = cw_exp_t'(cw_min);
    localparam cw_exp_t cw_max_exp = cw_exp_t'(cw_max);

    // exponent register file, one entry per queue
    cw_exp_t cw_exp_q [num_queues];

    // slot generator state
    logic [15:0] lfsr_q;
    logic        lfsr_fb;

    // selected queue values
    cw_exp_t     cur_exp;
    cw_exp_t     next_exp;
    logic [10:0] mask_wide;
    slot_cnt_t   slot_draw;
    logic        acked;

    // current exponent of the completing queue
    assign cur_exp = cw_exp_q[tx_queue_idx];
    assign acked   = tx_result[tx_ack_bit];

    // fibonacci taps 16,14,13,11
    // shift left, feedback enters at bit 0
    assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    // 2**exp - 1, exponent tops out at 10 so 11 bits suffice
    assign mask_wide = (11'd1 << cur_exp) - 11'd1;

    // draw uses the generator value before this step
    assign slot_draw = lfsr_q[9:0] & mask_wide[9:0];

    // window update
    // success drops back to the floor
    // failure doubles the window up to the ceiling
    always_comb begin
        if (acked) begin
            next_exp = cw_min_exp;
        end else if (cur_exp >= cw_max_exp) begin
            next_exp = cw_max_exp;
        end else begin
            next_exp = cur_exp + cw_exp_t'(1);
        end
    end

    // control state: exponents, generator, strobe
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int q = 0; q < num_queues; q++) begin
                cw_exp_q[q] <= cw_min_exp;
            end
            lfsr_q        <= lfsr_seed;
            attempt_valid <= 1'b0;
        end else begin
            attempt_valid <= tx_try_complete;
            if (tx_try_complete) begin
                // only the completing queue moves
                cw_exp_q[tx_queue_idx] <= next_exp;
                // one step per completion, idle cycles leave it alone
                lfsr_q <= {lfsr_q[14:0], lfsr_fb};
            end
        end
    end

    // attempt payload
    // loaded only on a completion, held otherwise
    always_ff @(posedge clk) begin
        if (tx_try_complete) begin
            attempt.cw_exp   <= cur_exp;
            attempt.slot_cnt <= slot_draw;
            attempt.prio     <= linux_prio;
            attempt.queue    <= tx_queue_idx;
            attempt.pkt_sn   <= tx_pkt_sn;
            attempt.result   <= tx_result;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
tx_status_cfg_pkg.sv
tx_status_types_pkg.sv
status_fifo_mem.sv
cw_backoff_tracker.sv
tx_status_fifo.sv
tx_status_top.sv
tb_tx_status.sv

// ==== status_fifo_mem.sv ====
// status buffer: single-clock circular FIFO with first-word-fall-through head
`timescale 1ns/100ps
`default_nettype none

module status_fifo_mem #(
    parameter int unsigned depth_log2 = 6,
    parameter int unsigned width      = 32
) (
    input  wire                    clk,
    input  wire                    rstn,

    // write side
    input  wire                    wr_en,
    input  wire [width-1:0]        wr_data,

    // read side, pop of the shown head word
    input  wire                    rd_en,
    output logic [width-1:0]       head,

    // status
    output logic                   empty,
    output logic                   full,
    output logic [depth_log2:0]    data_count
);

    localparam int unsigned depth = 1 << depth_log2;

    typedef logic [depth_log2-1:0] ptr_t;

    // storage, no reset on the payload
    logic [width-1:0] mem [depth];

    // pointers wrap naturally at depth
    ptr_t wr_ptr;
    ptr_t rd_ptr;

    // fill level, 0 .. depth
    logic [depth_log2:0] count;

    // qualified strobes
    logic do_wr;
    logic do_rd;

    // write into a full buffer is dropped
    assign do_wr = wr_en && !full;
    // pop of an empty buffer is ignored
    assign do_rd = rd_en && !empty;

    // memory write
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers and fill level
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_t'(wr_ptr + 1'b1);
            end
            if (do_rd) begin
                rd_ptr <= ptr_t'(rd_ptr + 1'b1);
            end
            // push and pop together leave the level as is
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fall-through head, valid whenever not empty
    assign head = mem[rd_ptr];

    // flags from the level
    assign empty = (count == '0);
    // top bit set only at count == depth
    assign full = count[depth_log2];

    assign data_count = count;

endmodule

`default_nettype wire

// ==== tb_tx_status.sv ====
// tx status testbench driving completions and register reads and checking log words against a model
`timescale 1ns/100ps
`default_nettype none

module tb_tx_status
    import tx_status_cfg_pkg::*;
    import tx_status_types_pkg::*;
();

    localparam int unsigned fifo_depth   = 1 << fifo_depth_log2_default;
    localparam int unsigned read_timeout = 50;
    localparam int unsigned drop_timeout = 40;

    logic           clk;
    logic           rstn;
    logic           tx_try_complete;
    tx_result_t     tx_result;
    prio_t          linux_prio;
    queue_idx_t     tx_queue_idx;
    pkt_sn_t        tx_pkt_sn;
    logic           slv_reg_rden;
    reg_addr_t      axi_araddr_core;
    tx_status_rec_t tx_status_out;
    drop_cnt_t      drop_count;

    // reference model state
    int unsigned    model_exp [num_queues];
    logic [15:0]    model_lfsr;
    int unsigned    model_drops;
    logic [9:0]     next_sn;
    logic [31:0]    expected_q [$];

    tx_status_top #(
        .cw_min          (cw_min_default),
        .cw_max          (cw_max_default),
        .fifo_depth_log2 (fifo_depth_log2_default)
    ) UUT (
        .clk             (clk),
        .rstn            (rstn),
        .tx_try_complete (tx_try_complete),
        .tx_result       (tx_result),
        .linux_prio      (linux_prio),
        .tx_queue_idx    (tx_queue_idx),
        .tx_pkt_sn       (tx_pkt_sn),
        .slv_reg_rden    (slv_reg_rden),
        .axi_araddr_core (axi_araddr_core),
        .tx_status_out   (tx_status_out),
        .drop_count      (drop_count)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while %s", $time, what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // fibonacci taps 16,14,13,11 shifting left
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // log word from the field rules with slot bit 9 added to the window
    function automatic logic [31:0] build_record(input int unsigned exp, input logic [15:0] gen,
                                                 input logic [1:0] prio, input logic [1:0] queue,
                                                 input logic [9:0] sn, input logic [4:0] res);
        int unsigned slot;
        logic [3:0]  logged;
        slot   = int'(gen) % (1 << exp);
        logged = 4'(exp + (slot >> 9));
        return {logged, slot[8:0], prio, queue, sn, res};
    endfunction

    task automatic go_idle(input int unsigned cycles);
        repeat (cycles) begin
            @(posedge clk);
            tx_try_complete <= 1'b0;
        end
    endtask

    // one completion plus model update and a gap of idle cycles after it
    task automatic send_completion(input logic [1:0] queue, input logic ack,
                                   input int unsigned gap);
        logic [4:0]  res;
        logic [1:0]  prio;
        logic [31:0] rec;
        res  = {ack, 4'($urandom)};
        prio = 2'($urandom);
        rec  = build_record(model_exp[queue], model_lfsr, prio, queue, next_sn, res);
        // buffer model assuming no reads during a burst
        if (expected_q.size() < fifo_depth) begin
            expected_q.push_back(rec);
        end else if (model_drops < 255) begin
            model_drops++;
        end
        // success returns to the floor and failure adds one up to the ceiling
        if (ack) begin
            model_exp[queue] = cw_min_default;
        end else if (model_exp[queue] < cw_max_default) begin
            model_exp[queue]++;
        end
        model_lfsr = lfsr_step(model_lfsr);
        @(posedge clk);
        tx_try_complete <= 1'b1;
        tx_result       <= res;
        linux_prio      <= prio;
        tx_queue_idx    <= queue;
        tx_pkt_sn       <= next_sn;
        next_sn++;
        go_idle(gap);
    endtask

    // sample on the falling edge away from the update
    task automatic wait_visible();
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while ((tx_status_out === '1) && (waited < read_timeout)) begin
            waited++;
            @(negedge clk);
        end
        if (waited >= read_timeout) begin
            report_timeout("waiting for a status word to appear");
        end
    endtask

    // strobe one cycle then wait one more edge for the empty flag
    task automatic pop_word();
        @(posedge clk);
        slv_reg_rden    <= 1'b1;
        axi_araddr_core <= tx_status_reg_addr;
        @(posedge clk);
        slv_reg_rden    <= 1'b0;
        axi_araddr_core <= '0;
        @(posedge clk);
    endtask

    task automatic read_expected();
        wait_visible();
        check_value("tx_status_out", expected_q[0], tx_status_out);
        void'(expected_q.pop_front());
        pop_word();
    endtask

    // reads at other addresses must leave the head in place
    task automatic read_other_addresses(input int unsigned count);
        reg_addr_t addr;
        wait_visible();
        check_value("tx_status_out", expected_q[0], tx_status_out);
        repeat (count) begin
            addr = 5'($urandom);
            if (addr == tx_status_reg_addr) begin
                addr = ~addr;
            end
            @(posedge clk);
            slv_reg_rden    <= 1'b1;
            axi_araddr_core <= addr;
            @(posedge clk);
            slv_reg_rden    <= 1'b0;
            axi_araddr_core <= '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("tx_status_out", expected_q[0], tx_status_out);
    endtask

    task automatic drain_and_check_empty();
        while (expected_q.size() > 0) begin
            read_expected();
        end
        @(negedge clk);
        check_value("tx_status_out", 32'hFFFF_FFFF, tx_status_out);
    endtask

    task automatic wait_drop_count(input int unsigned expected);
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while ((drop_count !== 8'(expected)) && (waited < drop_timeout)) begin
            waited++;
            @(negedge clk);
        end
        check_value("drop_count", 32'(expected), 32'(drop_count));
    endtask

    initial begin
        void'($urandom(58574));
        rstn            = 1'b0;
        tx_try_complete = 1'b0;
        tx_result       = '0;
        linux_prio      = '0;
        tx_queue_idx    = '0;
        tx_pkt_sn       = '0;
        slv_reg_rden    = 1'b0;
        axi_araddr_core = '0;
        for (int q = 0; q < num_queues; q++) begin
            model_exp[q] = cw_min_default;
        end
        model_lfsr  = lfsr_seed;
        model_drops = 0;
        next_sn     = '0;

        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        // reset values
        @(negedge clk);
        check_value("tx_status_out", 32'hFFFF_FFFF, tx_status_out);
        check_value("drop_count", 32'd0, 32'(drop_count));

        // random mix with many back to back
        for (int i = 0; i < 40; i++) begin
            send_completion(2'($urandom), 1'($urandom), (i == 39) ? 1 : ($urandom % 3));
        end
        drain_and_check_empty();

        // failure runs saturate the window and a success resets it
        for (int i = 0; i < 9; i++) begin
            send_completion(2'd2, 1'b0, 0);
        end
        send_completion(2'd0, 1'b0, 0);
        send_completion(2'd2, 1'b1, 0);
        send_completion(2'd2, 1'b0, 1);
        for (int i = 0; i < 12; i++) begin
            send_completion(2'd1, 1'b0, $urandom % 2);
        end
        send_completion(2'd1, 1'b1, 0);
        send_completion(2'd1, 1'b0, 0);
        send_completion(2'd3, 1'b0, 1);
        drain_and_check_empty();

        // idle gaps between completions where the generator must hold
        for (int i = 0; i < 30; i++) begin
            send_completion(2'($urandom), 1'($urandom), 1 + ($urandom % 6));
        end
        drain_and_check_empty();

        // foreign addresses pop nothing
        for (int i = 0; i < 3; i++) begin
            send_completion(2'($urandom), 1'($urandom), (i == 2) ? 1 : 0);
        end
        while (expected_q.size() > 0) begin
            read_other_addresses(1 + ($urandom % 4));
            read_expected();
        end
        @(negedge clk);
        check_value("tx_status_out", 32'hFFFF_FFFF, tx_status_out);

        // overflow with 67 records into 64 slots
        for (int i = 0; i < 67; i++) begin
            send_completion(2'($urandom), 1'($urandom), (i == 66) ? 1 : 0);
        end
        wait_drop_count(model_drops);
        check_value("drop_count", 32'd3, 32'(drop_count));
        drain_and_check_empty();
        check_value("drop_count", 32'd3, 32'(drop_count));

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tx_status_cfg_pkg.sv ====
// tx status config package: default parameters, register address and queue count
`default_nettype none

package tx_status_cfg_pkg;

    // contention window exponents
    // reset value and floor of the exponent
    localparam int unsigned cw_min_default = 4;
    // ceiling, a 10-bit slot count covers 2**10 slots
    localparam int unsigned cw_max_default = 10;

    // status buffer sizing, 2**6 = 64 records
    localparam int unsigned fifo_depth_log2_default = 6;

    // register map
    // host reads the status log through this word address
    localparam logic [4:0] tx_status_reg_addr = 5'h16;

    // queue setup
    // one exponent per access category queue
    localparam int unsigned num_queues = 4;

    // slot generator
    // reset state of the 16-bit lfsr, must be nonzero
    localparam logic [15:0] lfsr_seed = 16'hACE1;

endpackage

`default_nettype wire

// ==== tx_status_fifo.sv ====
// status logger packing attempts into 32-bit records, buffering them and serving register reads
`timescale 1ns/100ps
`default_nettype none

module tx_status_fifo
    import tx_status_cfg_pkg::*;
    import tx_status_types_pkg::*;
#(
    parameter int unsigned depth_log2 = fifo_depth_log2_default
) (
    input  wire              clk,
    input  wire              rstn,

    // register read from the bus slave
    input  wire              slv_reg_rden,
    input  wire reg_addr_t   axi_araddr_core,

    // attempt strobe from the backoff tracker without back-pressure
    input  wire              attempt_valid,
    input  wire tx_attempt_t attempt,

    output tx_status_rec_t   tx_status_out,
    output drop_cnt_t        drop_count
);

    // packed record
    tx_status_rec_t rec_d;

    // buffer side
    logic           rd_en;
    tx_status_rec_t head;
    logic           empty;
    logic           full;
    logic           empty_q;

    // record packing
    // slot bit 9 folds into the logged window by addition
    always_comb begin
        rec_d.log_cw  = attempt.cw_exp + cw_exp_t'(attempt.slot_cnt[9]);
        rec_d.slot_lo = attempt.slot_cnt[8:0];
        rec_d.prio    = attempt.prio;
        rec_d.queue   = attempt.queue;
        rec_d.pkt_sn  = attempt.pkt_sn;
        rec_d.result  = attempt.result;
    end

    // registered empty flag and drop counter
    always_ff @(posedge clk) begin
        if (!rstn) begin
            empty_q    <= 1'b1;
            drop_count <= '0;
        end else begin
            empty_q <= empty;
            // count lost records up to 255
            if (attempt_valid && full && (drop_count != '1)) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // only the status word address pops
    assign rd_en = slv_reg_rden && (axi_araddr_core == tx_status_reg_addr);

    // all ones marks an empty log to the host
    assign tx_status_out = empty_q ? '1 : head;

    // record buffer
    // the record enters on the edge after the attempt strobe
    status_fifo_mem #(
        .depth_log2 (depth_log2),
        .width      ($bits(tx_status_rec_t))
    ) status_fifo_mem_i (
        .clk        (clk),
        .rstn       (rstn),
        .wr_en      (attempt_valid),
        .wr_data    (rec_d),
        .rd_en      (rd_en),
        .head       (head),
        .empty      (empty),
        .full       (full),
        .data_count ()
    );

endmodule

`default_nettype wire

// ==== tx_status_top.sv ====
// tx status top: backoff tracker feeding the status logger
`timescale 1ns/100ps
`default_nettype none

module tx_status_top
    import tx_status_cfg_pkg::*;
    import tx_status_types_pkg::*;
#(
    parameter int unsigned cw_min          = cw_min_default,
    parameter int unsigned cw_max          = cw_max_default,
    parameter int unsigned fifo_depth_log2 = fifo_depth_log2_default
) (
    input  wire             clk,
    input  wire             rstn,

    // transmit completion, may pulse every cycle
    input  wire             tx_try_complete,
    input  wire tx_result_t tx_result,
    input  wire prio_t      linux_prio,
    input  wire queue_idx_t tx_queue_idx,
    input  wire pkt_sn_t    tx_pkt_sn,

    // host register read
    input  wire             slv_reg_rden,
    input  wire reg_addr_t  axi_araddr_core,

    output tx_status_rec_t  tx_status_out,
    output drop_cnt_t       drop_count
);

    // stage 1 to stage 2
    logic        attempt_valid;
    tx_attempt_t attempt;

    // stage 1, window and slot draw
    cw_backoff_tracker #(
        .cw_min          (cw_min),
        .cw_max          (cw_max)
    ) cw_backoff_tracker_i (
        .clk             (clk),
        .rstn            (rstn),
        .tx_try_complete (tx_try_complete),
        .tx_result       (tx_result),
        .linux_prio      (linux_prio),
        .tx_queue_idx    (tx_queue_idx),
        .tx_pkt_sn       (tx_pkt_sn),
        .attempt_valid   (attempt_valid),
        .attempt         (attempt)
    );

    // stage 2, record log and register read
    tx_status_fifo #(
        .depth_log2      (fifo_depth_log2)
    ) tx_status_fifo_i (
        .clk             (clk),
        .rstn            (rstn),
        .slv_reg_rden    (slv_reg_rden),
        .axi_araddr_core (axi_araddr_core),
        .attempt_valid   (attempt_valid),
        .attempt         (attempt),
        .tx_status_out   (tx_status_out),
        .drop_count      (drop_count)
    );

endmodule

`default_nettype wire

// ==== tx_status_types_pkg.sv ====
// tx status type package: field widths, attempt struct and 32-bit log record
`default_nettype none

package tx_status_types_pkg;

    // register address from the axi-lite core
    typedef logic [4:0] reg_addr_t;

    // backoff fields
    typedef logic [3:0] cw_exp_t;
    typedef logic [9:0] slot_cnt_t;

    // per-packet tags from the host side
    typedef logic [1:0] queue_idx_t;
    typedef logic [1:0] prio_t;
    typedef logic [9:0] pkt_sn_t;

    // bit 4 ack flag, bits 3..0 retry count (logged, not decoded)
    typedef logic [4:0] tx_result_t;
    localparam int unsigned tx_ack_bit = 4;

    // saturating count of records lost to a full buffer
    typedef logic [7:0] drop_cnt_t;

    // one finished attempt, stage 1 to stage 2
    // exponent is the value used for this attempt, before the update
    typedef struct packed {
        cw_exp_t    cw_exp;
        slot_cnt_t  slot_cnt;
        prio_t      prio;
        queue_idx_t queue;
        pkt_sn_t    pkt_sn;
        tx_result_t result;
    } tx_attempt_t;

    // host visible log word, msb first
    // log_cw holds exponent plus slot bit 9
    typedef struct packed {
        cw_exp_t    log_cw;
        logic [8:0] slot_lo;
        prio_t      prio;
        queue_idx_t queue;
        pkt_sn_t    pkt_sn;
        tx_result_t result;
    } tx_status_rec_t;

endpackage

`default_nettype wire
